/* src/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Width of the tag that marks a new item moving between stages
`define CPU_TAG_WIDTH 3

// Entries in the instruction queue in front of decode
`define CPU_QUEUE_DEPTH 2

// The supplier starts with one credit per queue entry
`define CPU_CREDITS `CPU_QUEUE_DEPTH

`define CPU_REGISTERS 32

`endif

/* src/cpu_pkg.sv */
package cpu_pkg;

	// Major opcodes of the supported RV32I groups
	typedef enum logic [6:0] {
		opcode_op = 7'b0110011,
		opcode_op_imm = 7'b0010011,
		opcode_lui = 7'b0110111,
		opcode_auipc = 7'b0010111,
		opcode_jal = 7'b1101111,
		opcode_jalr = 7'b1100111,
		opcode_branch = 7'b1100011,
		opcode_other = 7'b0000000
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		operand_rs1,
		operand_rs2,
		operand_pc,
		operand_imm
	} operand_t;

	// Encoded as funct3 of the branch instructions
	typedef enum logic [2:0] {
		branch_beq = 3'b000,
		branch_bne = 3'b001,
		branch_blt = 3'b100,
		branch_bge = 3'b101,
		branch_bltu = 3'b110,
		branch_bgeu = 3'b111
	} branch_t;

endpackage

/* src/cpu_decode.sv */
`timescale 1ns/1ns

module cpu_decode import cpu_pkg::*; (
	input logic [31:0] i_instruction,

	output logic [4:0] o_rs1_addr,
	output logic [4:0] o_rs2_addr,
	output logic [4:0] o_rd,
	output logic [31:0] o_imm,
	output alu_op_t o_alu_operation,
	output operand_t o_operand_a,
	output operand_t o_operand_b,
	output logic o_write_enable,
	output logic o_jump,
	output logic o_branch,
	output branch_t o_branch_condition,
	output logic o_link,
	output logic o_uses_rs1,
	output logic o_uses_rs2
);

	opcode_t opcode;
	logic [2:0] funct3;
	logic alternate;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] imm_b;

	// The alternate bit picks SUB and SRA where funct3 alone is ambiguous
	function automatic alu_op_t alu_from_funct3(input logic [2:0] funct, input logic alt);
		case (funct)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign funct3 = i_instruction[14:12];
	assign alternate = i_instruction[30];

	assign o_rs1_addr = i_instruction[19:15];
	assign o_rs2_addr = i_instruction[24:20];
	assign o_rd = i_instruction[11:7];
	assign o_branch_condition = branch_t'(funct3);

	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
		i_instruction[30:21], 1'b0};
	assign imm_b = {{20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
		i_instruction[11:8], 1'b0};

	always_comb begin
		case (i_instruction[6:0])
			opcode_op, opcode_op_imm, opcode_lui, opcode_auipc,
			opcode_jal, opcode_jalr, opcode_branch: opcode = opcode_t'(i_instruction[6:0]);
			default: opcode = opcode_other;
		endcase
	end

	always_comb begin
		o_imm = 32'b0;
		o_alu_operation = alu_add;
		o_operand_a = operand_rs1;
		o_operand_b = operand_rs2;
		o_write_enable = 1'b0;
		o_jump = 1'b0;
		o_branch = 1'b0;
		o_link = 1'b0;
		o_uses_rs1 = 1'b0;
		o_uses_rs2 = 1'b0;
		case (opcode)
			opcode_op: begin
				o_alu_operation = alu_from_funct3(funct3, alternate);
				o_write_enable = 1'b1;
				o_uses_rs1 = 1'b1;
				o_uses_rs2 = 1'b1;
			end
			opcode_op_imm: begin
				// ADDI has no subtract form, so only SRAI looks at bit 30
				o_alu_operation = alu_from_funct3(funct3, alternate && funct3 == 3'b101);
				o_operand_b = operand_imm;
				o_imm = imm_i;
				o_write_enable = 1'b1;
				o_uses_rs1 = 1'b1;
			end
			opcode_lui: begin
				o_alu_operation = alu_pass_b;
				o_operand_b = operand_imm;
				o_imm = imm_u;
				o_write_enable = 1'b1;
			end
			opcode_auipc: begin
				o_operand_a = operand_pc;
				o_operand_b = operand_imm;
				o_imm = imm_u;
				o_write_enable = 1'b1;
			end
			opcode_jal: begin
				o_operand_a = operand_pc;
				o_operand_b = operand_imm;
				o_imm = imm_j;
				o_write_enable = 1'b1;
				o_jump = 1'b1;
				o_link = 1'b1;
			end
			opcode_jalr: begin
				o_operand_b = operand_imm;
				o_imm = imm_i;
				o_write_enable = 1'b1;
				o_jump = 1'b1;
				o_link = 1'b1;
				o_uses_rs1 = 1'b1;
			end
			opcode_branch: begin
				o_imm = imm_b;
				o_branch = 1'b1;
				o_uses_rs1 = 1'b1;
				o_uses_rs2 = 1'b1;
			end
			default: begin
				// Unsupported opcodes pass through as a no-op
				o_write_enable = 1'b0;
			end
		endcase
	end

endmodule

/* src/cpu_register_file.sv */
`include "cpu_settings.svh"

`timescale 1ns/1ns

module cpu_register_file (
	input logic i_clock,

	input logic [4:0] i_read_addr1,
	input logic [4:0] i_read_addr2,

	input logic i_write_enable,
	input logic [4:0] i_write_addr,
	input logic [31:0] i_write_data,

	output logic [31:0] o_read_data1,
	output logic [31:0] o_read_data2
);

	logic [31:0] registers [`CPU_REGISTERS];
	logic write_live;

	assign write_live = i_write_enable && i_write_addr != 5'd0;

	always_ff @(posedge i_clock) begin
		if (write_live) begin
			registers[i_write_addr] <= i_write_data;
		end
	end

	// A write in the same cycle is forwarded so the reader sees the new value
	always_comb begin
		if (i_read_addr1 == 5'd0) o_read_data1 = 32'b0;
		else if (write_live && i_read_addr1 == i_write_addr) o_read_data1 = i_write_data;
		else o_read_data1 = registers[i_read_addr1];

		if (i_read_addr2 == 5'd0) o_read_data2 = 32'b0;
		else if (write_live && i_read_addr2 == i_write_addr) o_read_data2 = i_write_data;
		else o_read_data2 = registers[i_read_addr2];
	end

endmodule

/* src/cpu_hazard.sv */
`include "cpu_settings.svh"

`timescale 1ns/1ns

module cpu_hazard import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,

	input logic [`CPU_TAG_WIDTH-1:0] i_tag,
	input logic [31:0] i_pc,
	input logic [31:0] i_rs1,
	input logic [31:0] i_rs2,
	input logic [4:0] i_rd,
	input logic [31:0] i_imm,
	input alu_op_t i_alu_operation,
	input operand_t i_operand_a,
	input operand_t i_operand_b,
	input logic i_write_enable,
	input logic i_jump,
	input logic i_branch,
	input branch_t i_branch_condition,
	input logic i_link,

	output logic [`CPU_TAG_WIDTH-1:0] o_tag,
	output logic [31:0] o_pc,
	output logic [31:0] o_rs1,
	output logic [31:0] o_rs2,
	output logic [4:0] o_rd,
	output logic [31:0] o_imm,
	output alu_op_t o_alu_operation,
	output operand_t o_operand_a,
	output operand_t o_operand_b,
	output logic o_write_enable,
	output logic o_jump,
	output logic o_branch,
	output branch_t o_branch_condition,
	output logic o_link
);

	logic load;

	// A new bundle is marked by a tag that differs from the one held here
	assign load = !i_stall && i_tag != o_tag;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_tag <= '0;
		end else if (load) begin
			o_tag <= i_tag;
		end
	end

	always_ff @(posedge i_clock) begin
		if (load) begin
			o_pc <= i_pc;
			o_rs1 <= i_rs1;
			o_rs2 <= i_rs2;
			o_rd <= i_rd;
			o_imm <= i_imm;
			o_alu_operation <= i_alu_operation;
			o_operand_a <= i_operand_a;
			o_operand_b <= i_operand_b;
			o_write_enable <= i_write_enable;
			o_jump <= i_jump;
			o_branch <= i_branch;
			o_branch_condition <= i_branch_condition;
			o_link <= i_link;
		end
	end

endmodule

/* src/cpu_execute.sv */
`include "cpu_settings.svh"

`timescale 1ns/1ns

module cpu_execute import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_hold,

	input logic [`CPU_TAG_WIDTH-1:0] i_tag,
	input logic [31:0] i_pc,
	input logic [31:0] i_rs1,
	input logic [31:0] i_rs2,
	input logic [4:0] i_rd,
	input logic [31:0] i_imm,
	input alu_op_t i_alu_operation,
	input operand_t i_operand_a,
	input operand_t i_operand_b,
	input logic i_write_enable,
	input logic i_jump,
	input logic i_branch,
	input branch_t i_branch_condition,
	input logic i_link,

	output logic [`CPU_TAG_WIDTH-1:0] o_tag,
	output logic o_wb_valid,
	output logic [4:0] o_wb_rd,
	output logic [31:0] o_wb_data,
	output logic o_wb_write_enable,
	output logic o_branch_taken,
	output logic [31:0] o_branch_target
);

	logic load;
	logic [31:0] operand_a;
	logic [31:0] operand_b;
	logic [31:0] alu_result;
	logic [31:0] result;
	logic condition_met;
	logic taken;
	logic is_jalr;
	logic [31:0] target_sum;
	logic [31:0] target;

	function automatic logic [31:0] select_operand(input operand_t select,
		input logic [31:0] rs1, input logic [31:0] rs2,
		input logic [31:0] pc, input logic [31:0] imm);
		case (select)
			operand_rs1: return rs1;
			operand_rs2: return rs2;
			operand_pc: return pc;
			default: return imm;
		endcase
	endfunction

	assign load = !i_hold && i_tag != o_tag;

	assign operand_a = select_operand(i_operand_a, i_rs1, i_rs2, i_pc, i_imm);
	assign operand_b = select_operand(i_operand_b, i_rs1, i_rs2, i_pc, i_imm);

	always_comb begin
		case (i_alu_operation)
			alu_add: alu_result = operand_a + operand_b;
			alu_sub: alu_result = operand_a - operand_b;
			alu_sll: alu_result = operand_a << operand_b[4:0];
			alu_slt: alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			alu_sltu: alu_result = {31'b0, operand_a < operand_b};
			alu_xor: alu_result = operand_a ^ operand_b;
			alu_srl: alu_result = operand_a >> operand_b[4:0];
			alu_sra: alu_result = $unsigned($signed(operand_a) >>> operand_b[4:0]);
			alu_or: alu_result = operand_a | operand_b;
			alu_and: alu_result = operand_a & operand_b;
			default: alu_result = operand_b;
		endcase
	end

	// Jumps write the return address instead of the ALU result
	assign result = i_link ? i_pc + 32'd4 : alu_result;

	always_comb begin
		case (i_branch_condition)
			branch_beq: condition_met = i_rs1 == i_rs2;
			branch_bne: condition_met = i_rs1 != i_rs2;
			branch_blt: condition_met = $signed(i_rs1) < $signed(i_rs2);
			branch_bge: condition_met = $signed(i_rs1) >= $signed(i_rs2);
			branch_bltu: condition_met = i_rs1 < i_rs2;
			branch_bgeu: condition_met = i_rs1 >= i_rs2;
			default: condition_met = 1'b0;
		endcase
	end

	assign taken = i_jump || (i_branch && condition_met);

	// JALR is the only jump that takes its base from rs1
	assign is_jalr = i_jump && i_operand_a == operand_rs1;
	assign target_sum = (is_jalr ? i_rs1 : i_pc) + i_imm;
	assign target = is_jalr ? {target_sum[31:1], 1'b0} : target_sum;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_tag <= '0;
			o_wb_valid <= 1'b0;
			o_wb_write_enable <= 1'b0;
			o_branch_taken <= 1'b0;
		end else begin
			o_wb_valid <= load;
			o_wb_write_enable <= load && i_write_enable;
			if (load) begin
				o_tag <= i_tag;
				o_branch_taken <= taken;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (load) begin
			o_wb_rd <= i_rd;
			o_wb_data <= result;
			o_branch_target <= target;
		end
	end

endmodule

/* src/cpu_control.sv */
`include "cpu_settings.svh"

`timescale 1ns/1ns

module cpu_control (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [31:0] i_instruction,
	input logic [31:0] i_pc,
	input logic i_hold,

	input logic [`CPU_TAG_WIDTH-1:0] i_stage_tag,
	input logic [4:0] i_stage_rd,
	input logic i_stage_write_enable,
	input logic [`CPU_TAG_WIDTH-1:0] i_wb_tag,

	input logic i_uses_rs1,
	input logic i_uses_rs2,
	input logic [4:0] i_rs1_addr,
	input logic [4:0] i_rs2_addr,

	output logic [31:0] o_head_instruction,
	output logic [31:0] o_head_pc,
	output logic [`CPU_TAG_WIDTH-1:0] o_head_tag,
	output logic o_stall,
	output logic o_credit
);

	localparam int pointer_width = $clog2(`CPU_QUEUE_DEPTH);
	localparam int count_width = $clog2(`CPU_QUEUE_DEPTH + 1);

	logic [31:0] queue_instruction [`CPU_QUEUE_DEPTH];
	logic [31:0] queue_pc [`CPU_QUEUE_DEPTH];
	logic [pointer_width-1:0] write_pointer;
	logic [pointer_width-1:0] read_pointer;
	logic [count_width-1:0] count;
	logic [`CPU_TAG_WIDTH-1:0] tag_count;
	logic not_empty;
	logic stage_pending;
	logic raw_hit;
	logic dequeue;

	function automatic logic [pointer_width-1:0] next_pointer(
		input logic [pointer_width-1:0] pointer);
		if (pointer == pointer_width'(`CPU_QUEUE_DEPTH - 1)) return '0;
		return pointer + 1'b1;
	endfunction

	assign not_empty = count != '0;

	// The stage instruction has not reached writeback while the two tags differ
	assign stage_pending = i_stage_tag != i_wb_tag;
	assign raw_hit = stage_pending && i_stage_write_enable && i_stage_rd != 5'd0 &&
		((i_uses_rs1 && i_rs1_addr == i_stage_rd) || (i_uses_rs2 && i_rs2_addr == i_stage_rd));

	assign o_stall = i_hold || raw_hit;
	assign dequeue = not_empty && !o_stall;

	assign o_head_instruction = queue_instruction[read_pointer];
	assign o_head_pc = queue_pc[read_pointer];
	// The head carries the next tag only when there is something to take
	assign o_head_tag = tag_count + {{(`CPU_TAG_WIDTH - 1){1'b0}}, not_empty};

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			queue_instruction[write_pointer] <= i_instruction;
			queue_pc[write_pointer] <= i_pc;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			count <= '0;
			tag_count <= '0;
			o_credit <= 1'b0;
		end else begin
			o_credit <= dequeue;
			if (i_valid) write_pointer <= next_pointer(write_pointer);
			if (dequeue) begin
				read_pointer <= next_pointer(read_pointer);
				tag_count <= tag_count + 1'b1;
			end
			case ({i_valid, dequeue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/cpu_core.sv */
`include "cpu_settings.svh"

`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [31:0] i_instruction,
	input logic [31:0] i_pc,
	input logic i_hold,

	output logic o_credit,
	output logic o_wb_valid,
	output logic [4:0] o_wb_rd,
	output logic [31:0] o_wb_data,
	output logic o_branch_taken,
	output logic [31:0] o_branch_target
);

	logic [31:0] head_instruction;
	logic [31:0] head_pc;
	logic [`CPU_TAG_WIDTH-1:0] head_tag;
	logic stall;

	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	logic [4:0] rd;
	logic [31:0] imm;
	alu_op_t alu_operation;
	operand_t operand_a;
	operand_t operand_b;
	logic write_enable;
	logic jump;
	logic branch;
	branch_t branch_condition;
	logic link;
	logic uses_rs1;
	logic uses_rs2;

	logic [31:0] rs1_data;
	logic [31:0] rs2_data;

	logic [`CPU_TAG_WIDTH-1:0] stage_tag;
	logic [31:0] stage_pc;
	logic [31:0] stage_rs1;
	logic [31:0] stage_rs2;
	logic [4:0] stage_rd;
	logic [31:0] stage_imm;
	alu_op_t stage_alu_operation;
	operand_t stage_operand_a;
	operand_t stage_operand_b;
	logic stage_write_enable;
	logic stage_jump;
	logic stage_branch;
	branch_t stage_branch_condition;
	logic stage_link;

	logic [`CPU_TAG_WIDTH-1:0] wb_tag;
	logic wb_write_enable;

	cpu_control i_control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_instruction(i_instruction),
		.i_pc(i_pc),
		.i_hold(i_hold),
		.i_stage_tag(stage_tag),
		.i_stage_rd(stage_rd),
		.i_stage_write_enable(stage_write_enable),
		.i_wb_tag(wb_tag),
		.i_uses_rs1(uses_rs1),
		.i_uses_rs2(uses_rs2),
		.i_rs1_addr(rs1_addr),
		.i_rs2_addr(rs2_addr),
		.o_head_instruction(head_instruction),
		.o_head_pc(head_pc),
		.o_head_tag(head_tag),
		.o_stall(stall),
		.o_credit(o_credit)
	);

	cpu_decode i_decode (
		.i_instruction(head_instruction),
		.o_rs1_addr(rs1_addr),
		.o_rs2_addr(rs2_addr),
		.o_rd(rd),
		.o_imm(imm),
		.o_alu_operation(alu_operation),
		.o_operand_a(operand_a),
		.o_operand_b(operand_b),
		.o_write_enable(write_enable),
		.o_jump(jump),
		.o_branch(branch),
		.o_branch_condition(branch_condition),
		.o_link(link),
		.o_uses_rs1(uses_rs1),
		.o_uses_rs2(uses_rs2)
	);

	// Writeback drives the write port during its one valid cycle
	cpu_register_file i_register_file (
		.i_clock(i_clock),
		.i_read_addr1(rs1_addr),
		.i_read_addr2(rs2_addr),
		.i_write_enable(wb_write_enable),
		.i_write_addr(o_wb_rd),
		.i_write_data(o_wb_data),
		.o_read_data1(rs1_data),
		.o_read_data2(rs2_data)
	);

	cpu_hazard i_hazard (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(stall),
		.i_tag(head_tag),
		.i_pc(head_pc),
		.i_rs1(rs1_data),
		.i_rs2(rs2_data),
		.i_rd(rd),
		.i_imm(imm),
		.i_alu_operation(alu_operation),
		.i_operand_a(operand_a),
		.i_operand_b(operand_b),
		.i_write_enable(write_enable),
		.i_jump(jump),
		.i_branch(branch),
		.i_branch_condition(branch_condition),
		.i_link(link),
		.o_tag(stage_tag),
		.o_pc(stage_pc),
		.o_rs1(stage_rs1),
		.o_rs2(stage_rs2),
		.o_rd(stage_rd),
		.o_imm(stage_imm),
		.o_alu_operation(stage_alu_operation),
		.o_operand_a(stage_operand_a),
		.o_operand_b(stage_operand_b),
		.o_write_enable(stage_write_enable),
		.o_jump(stage_jump),
		.o_branch(stage_branch),
		.o_branch_condition(stage_branch_condition),
		.o_link(stage_link)
	);

	cpu_execute i_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hold(i_hold),
		.i_tag(stage_tag),
		.i_pc(stage_pc),
		.i_rs1(stage_rs1),
		.i_rs2(stage_rs2),
		.i_rd(stage_rd),
		.i_imm(stage_imm),
		.i_alu_operation(stage_alu_operation),
		.i_operand_a(stage_operand_a),
		.i_operand_b(stage_operand_b),
		.i_write_enable(stage_write_enable),
		.i_jump(stage_jump),
		.i_branch(stage_branch),
		.i_branch_condition(stage_branch_condition),
		.i_link(stage_link),
		.o_tag(wb_tag),
		.o_wb_valid(o_wb_valid),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data),
		.o_wb_write_enable(wb_write_enable),
		.o_branch_taken(o_branch_taken),
		.o_branch_target(o_branch_target)
	);

endmodule

/* test/cpu_core_tb.sv */
`include "cpu_settings.svh"

`timescale 1ns/1ns

module cpu_core_tb;

	localparam int row_limit = 48;

	// RV32I major opcodes as given by the instruction set manual
	localparam logic [6:0] opcode_op_imm = 7'b0010011;
	localparam logic [6:0] opcode_lui = 7'b0110111;
	localparam logic [6:0] opcode_auipc = 7'b0010111;
	localparam logic [6:0] opcode_jalr = 7'b1100111;

	logic clock = 1'b0;
	logic reset;
	logic valid;
	logic [31:0] instruction;
	logic [31:0] pc;
	logic hold;
	logic credit;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;
	logic branch_taken;
	logic [31:0] branch_target;

	string row_name [row_limit];
	logic [31:0] row_instruction [row_limit];
	logic [31:0] row_pc [row_limit];
	logic row_writes [row_limit];
	logic [4:0] row_rd [row_limit];
	logic [31:0] row_data [row_limit];
	logic row_taken [row_limit];
	logic row_check_target [row_limit];
	logic [31:0] row_target [row_limit];

	int row_count = 0;
	int sent = 0;
	int received = 0;
	int credits = `CPU_CREDITS;
	int returned = 0;
	int errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic timed_out = 1'b0;
	logic [15:0] lfsr_state = 16'd7;

	cpu_core i_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_valid(valid),
		.i_instruction(instruction),
		.i_pc(pc),
		.i_hold(hold),
		.o_credit(credit),
		.o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd),
		.o_wb_data(wb_data),
		.o_branch_taken(branch_taken),
		.o_branch_target(branch_target)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] r_type(input int funct7, input int rs2, input int rs1,
		input int funct3, input int rd);
		return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input int funct3,
		input int rd, input logic [6:0] opcode);
		logic [31:0] value;
		value = imm;
		return {value[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode};
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd,
		input logic [6:0] opcode);
		logic [31:0] value;
		value = imm;
		return {value[19:0], rd[4:0], opcode};
	endfunction

	function automatic logic [31:0] j_type(input int offset, input int rd);
		logic [31:0] value;
		value = offset;
		return {value[20], value[10:1], value[11], value[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] b_type(input int offset, input int rs2, input int rs1,
		input int funct3);
		logic [31:0] value;
		value = offset;
		return {value[12], value[10:5], rs2[4:0], rs1[4:0], funct3[2:0], value[4:1],
			value[11], 7'b1100011};
	endfunction

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	// Rows run at consecutive word addresses from 0x100
	task automatic store_row(input string name, input logic [31:0] word, input logic writes,
		input int rd, input logic [31:0] data, input logic taken, input logic check_target,
		input logic [31:0] target);
		row_name[row_count] = name;
		row_instruction[row_count] = word;
		row_pc[row_count] = 32'h100 + 4 * row_count;
		row_writes[row_count] = writes;
		row_rd[row_count] = rd[4:0];
		row_data[row_count] = data;
		row_taken[row_count] = taken;
		row_check_target[row_count] = check_target;
		row_target[row_count] = target;
		row_count++;
	endtask

	task automatic write_row(input string name, input logic [31:0] word, input int rd,
		input logic [31:0] data);
		store_row(name, word, 1'b1, rd, data, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic branch_row(input string name, input logic [31:0] word, input logic taken,
		input logic [31:0] target);
		store_row(name, word, 1'b0, 0, 32'h0, taken, 1'b1, target);
	endtask

	task automatic jump_row(input string name, input logic [31:0] word, input int rd,
		input logic [31:0] data, input logic [31:0] target);
		store_row(name, word, 1'b1, rd, data, 1'b1, 1'b1, target);
	endtask

	task automatic quiet_row(input string name, input logic [31:0] word);
		store_row(name, word, 1'b0, 0, 32'h0, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic build_table();
		write_row("addi x1", i_type(5, 0, 0, 1, opcode_op_imm), 1, 32'd5);
		write_row("addi x2", i_type(-3, 0, 0, 2, opcode_op_imm), 2, 32'hFFFFFFFD);
		write_row("add x3", r_type(0, 2, 1, 0, 3), 3, 32'd2);
		write_row("sub x4", r_type(32, 2, 1, 0, 4), 4, 32'd8);
		write_row("slli x5", i_type(3, 1, 1, 5, opcode_op_imm), 5, 32'h28);
		write_row("srai x6", i_type(32'h401, 2, 5, 6, opcode_op_imm), 6, 32'hFFFFFFFE);
		write_row("srli x7", i_type(28, 2, 5, 7, opcode_op_imm), 7, 32'hF);
		write_row("sll x8", r_type(0, 4, 1, 1, 8), 8, 32'h500);
		write_row("slt x9", r_type(0, 1, 2, 2, 9), 9, 32'd1);
		write_row("sltu x10", r_type(0, 1, 2, 3, 10), 10, 32'd0);
		write_row("xori x11", i_type(255, 1, 4, 11, opcode_op_imm), 11, 32'hFA);
		write_row("or x12", r_type(0, 4, 1, 6, 12), 12, 32'hD);
		write_row("and x13", r_type(0, 12, 11, 7, 13), 13, 32'h8);
		write_row("sra x14", r_type(32, 1, 2, 5, 14), 14, 32'hFFFFFFFF);
		write_row("srl x15", r_type(0, 1, 2, 5, 15), 15, 32'h07FFFFFF);
		write_row("lui x16", u_type(32'h12345, 16, opcode_lui), 16, 32'h12345000);
		write_row("auipc x17", u_type(1, 17, opcode_auipc), 17, 32'h1140);
		write_row("addi x16", i_type(32'h678, 16, 0, 16, opcode_op_imm), 16, 32'h12345678);
		branch_row("beq taken", b_type(16, 1, 1, 0), 1'b1, 32'h158);
		branch_row("beq not taken", b_type(16, 2, 1, 0), 1'b0, 32'h15C);
		branch_row("bne taken", b_type(-8, 2, 1, 1), 1'b1, 32'h148);
		branch_row("bne not taken", b_type(-8, 1, 1, 1), 1'b0, 32'h14C);
		branch_row("blt taken", b_type(32, 1, 2, 4), 1'b1, 32'h178);
		branch_row("blt not taken", b_type(32, 2, 1, 4), 1'b0, 32'h17C);
		branch_row("bge taken", b_type(12, 2, 1, 5), 1'b1, 32'h16C);
		branch_row("bge not taken", b_type(12, 1, 2, 5), 1'b0, 32'h170);
		branch_row("bltu taken", b_type(20, 2, 1, 6), 1'b1, 32'h17C);
		branch_row("bltu not taken", b_type(20, 1, 2, 6), 1'b0, 32'h180);
		branch_row("bgeu taken", b_type(-4, 1, 2, 7), 1'b1, 32'h16C);
		branch_row("bgeu not taken", b_type(-4, 4, 3, 7), 1'b0, 32'h170);
		jump_row("jal x19", j_type(64, 19), 19, 32'h17C, 32'h1B8);
		jump_row("jalr x20", i_type(3, 19, 0, 20, opcode_jalr), 20, 32'h180, 32'h17E);
		write_row("addi x0", i_type(7, 0, 0, 0, opcode_op_imm), 0, 32'd7);
		jump_row("jal x0", j_type(8, 0), 0, 32'h188, 32'h18C);
		write_row("add x21 from x0", r_type(0, 1, 0, 0, 21), 21, 32'd5);
		// Its rd field names x21, which the next row reads
		quiet_row("unknown opcode", 32'h00007A8B);
		write_row("add x22", r_type(0, 16, 21, 0, 22), 22, 32'h1234567D);
	endtask

	task automatic check_writeback();
		int n;
		n = received;
		if (n >= row_count) begin
			$display("A writeback arrived after the whole table was done, rd %0d", wb_rd);
			errors++;
		end else begin
			if (row_writes[n] && wb_rd !== row_rd[n]) begin
				$display("FAILED %s rd: expected %0d, actual %0d", row_name[n], row_rd[n], wb_rd);
				errors++;
			end
			if (row_writes[n] && wb_data !== row_data[n]) begin
				$display("FAILED %s data: expected %h, actual %h", row_name[n], row_data[n],
					wb_data);
				errors++;
			end
			if (branch_taken !== row_taken[n]) begin
				$display("FAILED %s taken: expected %b, actual %b", row_name[n], row_taken[n],
					branch_taken);
				errors++;
			end
			if (row_check_target[n] && branch_target !== row_target[n]) begin
				$display("FAILED %s target: expected %h, actual %h", row_name[n],
					row_target[n], branch_target);
				errors++;
			end
		end
		received++;
	endtask

	// Outputs are sampled on the falling edge, where they are stable
	task automatic collect_outputs();
		if (wb_valid) begin
			if (hold) begin
				$display("A writeback came out while the pipeline was held");
				errors++;
			end
			check_writeback();
		end
		if (credit) begin
			if (hold) begin
				$display("A credit came back while the pipeline was held");
				errors++;
			end
			credits++;
			returned++;
			if (credits > `CPU_CREDITS) begin
				$display("The core returned more credits than it was given");
				errors++;
			end
		end
	endtask

	task automatic drive_supplier();
		logic first;
		if (credits > 0 && sent < row_count) begin
			valid = 1'b1;
			instruction = row_instruction[sent];
			pc = row_pc[sent];
			credits--;
			sent++;
		end else begin
			valid = 1'b0;
		end
		// Two LFSR bits per cycle, so the core is held about a quarter of the time
		lfsr_state = lfsr_step(lfsr_state);
		first = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		hold = first & lfsr_state[0];
	endtask

	initial begin
		reset = 1'b1;
		valid = 1'b0;
		instruction = 32'h0;
		pc = 32'h0;
		hold = 1'b0;
		build_table();
		cycle_limit = 20 * row_count;
		repeat (4) @(negedge clock);
		reset = 1'b0;

		while (received < row_count && cycle_count < cycle_limit) begin
			@(negedge clock);
			cycle_count++;
			collect_outputs();
			drive_supplier();
		end
		if (received < row_count) begin
			$display("Timeout after %0d cycles with only %0d writebacks", cycle_count,
				received);
			timed_out = 1'b1;
		end

		// Let the pipeline drain to catch duplicate writebacks and late credits
		valid = 1'b0;
		hold = 1'b0;
		repeat (8) begin
			@(negedge clock);
			collect_outputs();
		end
		if (returned != sent) begin
			$display("The core returned %0d credits for %0d words sent", returned, sent);
			errors++;
		end

		$display("Errors %0d, writebacks %0d of %0d, words sent %0d, credits returned %0d",
			errors, received, row_count, sent, returned);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+src
src/cpu_pkg.sv
src/cpu_decode.sv
src/cpu_register_file.sv
src/cpu_hazard.sv
src/cpu_execute.sv
src/cpu_control.sv
src/cpu_core.sv
test/cpu_core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = cpu_core_tb
FILE_LIST = list.f
BUILD_DIR = obj_dir
LOG = simulate.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
